/* bench/tb_clock_gen.sv */
//////////////////////////////////////////////////////////////////////
// Testbench clock source
// Free running clock with a 4 ns period
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  localparam int HALF_PERIOD = 2;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

/* bench/tb_rv_core_shell.sv */
//////////////////////////////////////////////////////////////////////
// Register file shell testbench
// Random and directed traffic against a reference register model,
// checked by concurrent assertions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rv_shell_defs.svh"

module tb_rv_core_shell;

  localparam int RESET_CYCLES = 16;
  localparam int WAKE_TIMEOUT = 20;

  logic                    clk;
  logic                    rst_n;
  logic                    fetch_enable;
  logic                    core_busy;
  logic                    debug_req;
  logic                    irq_pending;
  logic                    irq_nm;
  logic                    rf_we;
  rv_shell_pkg::reg_addr_t rf_waddr;
  logic [`RV_XLEN-1:0]     rf_wdata;
  rv_shell_pkg::reg_addr_t rf_raddr_a;
  rv_shell_pkg::reg_addr_t rf_raddr_b;
  logic [`RV_XLEN-1:0]     rf_rdata_a;
  logic [`RV_XLEN-1:0]     rf_rdata_b;
  logic                    core_sleep;
  logic                    alert_major;

  // Reference state
  logic [`RV_XLEN-1:0] model [`RV_NUM_REGS];
  logic                fe_m;
  logic                busy_m;
  logic                awake_m;
  logic [31:0]         lfsr_q;

  tb_clock_gen u_clk_gen (
    .clk_o (clk)
  );

  rv_core_shell UUT (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .fetch_enable_i (fetch_enable),
    .core_busy_i    (core_busy),
    .debug_req_i    (debug_req),
    .irq_pending_i  (irq_pending),
    .irq_nm_i       (irq_nm),
    .rf_we_i        (rf_we),
    .rf_waddr_i     (rf_waddr),
    .rf_wdata_i     (rf_wdata),
    .rf_raddr_a_i   (rf_raddr_a),
    .rf_raddr_b_i   (rf_raddr_b),
    .rf_rdata_a_o   (rf_rdata_a),
    .rf_rdata_b_o   (rf_rdata_b),
    .core_sleep_o   (core_sleep),
    .alert_major_o  (alert_major)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Awake once fetch is enabled and any wake source is present
  assign awake_m = fe_m & (busy_m | debug_req | irq_pending | irq_nm);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fe_m   <= 1'b0;
      busy_m <= 1'b0;
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        model[i] <= '0;
      end
    end else begin
      if (fetch_enable) begin
        fe_m <= 1'b1;
      end
      busy_m <= core_busy;
      // x0 never changes
      if (rf_we && awake_m && (rf_waddr != '0)) begin
        model[rf_waddr] <= rf_wdata;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic drive_cycle(
    input logic                    we,
    input rv_shell_pkg::reg_addr_t waddr,
    input logic [`RV_XLEN-1:0]     wdata,
    input rv_shell_pkg::reg_addr_t ra,
    input rv_shell_pkg::reg_addr_t rb,
    input logic [3:0]              wake
  );
    @(posedge clk);
    rf_we       <= we;
    rf_waddr    <= waddr;
    rf_wdata    <= wdata;
    rf_raddr_a  <= ra;
    rf_raddr_b  <= rb;
    core_busy   <= wake[0];
    debug_req   <= wake[1];
    irq_pending <= wake[2];
    irq_nm      <= wake[3];
  endtask

  task automatic random_cycle(input logic allow_wake);
    logic [31:0] we;
    logic [31:0] waddr;
    logic [31:0] wdata;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] wake;
    draw_bits(1, we);
    draw_bits(`RV_REG_AW, waddr);
    draw_bits(`RV_XLEN, wdata);
    draw_bits(`RV_REG_AW, ra);
    draw_bits(`RV_REG_AW, rb);
    draw_bits(4, wake);
    if (!allow_wake) begin
      wake = '0;
    end
    drive_cycle(we[0], waddr[4:0], wdata, ra[4:0], rb[4:0], wake[3:0]);
  endtask

  task automatic wait_sleep(input logic level, input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > WAKE_TIMEOUT) begin
        abort_run($sformatf("Timeout after %0d cycles waiting for the core to %s",
                            WAKE_TIMEOUT, what));
      end
    end while (core_sleep !== level);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  sleep_rule_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    core_sleep == !awake_m
  ) else abort_run($sformatf("Mismatch at %0t: core_sleep_o is %b, expected %b",
                             $time, $sampled(core_sleep), !$sampled(awake_m)));

  read_a_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    rf_rdata_a == model[rf_raddr_a]
  ) else abort_run($sformatf("Mismatch at %0t: port A x%0d read %h, expected %h",
                             $time, $sampled(rf_raddr_a), $sampled(rf_rdata_a),
                             model[$sampled(rf_raddr_a)]));

  read_b_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    rf_rdata_b == model[rf_raddr_b]
  ) else abort_run($sformatf("Mismatch at %0t: port B x%0d read %h, expected %h",
                             $time, $sampled(rf_raddr_b), $sampled(rf_rdata_b),
                             model[$sampled(rf_raddr_b)]));

  x0_zero_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    ((rf_raddr_a == '0) -> (rf_rdata_a == '0)) &&
    ((rf_raddr_b == '0) -> (rf_rdata_b == '0))
  ) else abort_run($sformatf("Mismatch at %0t: x0 read back nonzero", $time));

  alert_quiet_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    alert_major == 1'b0
  ) else abort_run($sformatf("Mismatch at %0t: alert_major_o raised on a clean read",
                             $time));

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] v;
    lfsr_q       = 32'd85570;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    core_busy    = 1'b0;
    debug_req    = 1'b0;
    irq_pending  = 1'b0;
    irq_nm       = 1'b0;
    rf_we        = 1'b0;
    rf_waddr     = '0;
    rf_wdata     = '0;
    rf_raddr_a   = '0;
    rf_raddr_b   = '0;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // Wake sources toggle, no fetch enable yet
    repeat (30) random_cycle(1'b1);

    // Single cycle fetch enable pulse
    drive_cycle(1'b0, '0, '0, '0, '0, 4'b0001);
    fetch_enable <= 1'b1;
    @(posedge clk);
    fetch_enable <= 1'b0;
    wait_sleep(1'b0, "wake up");

    repeat (300) random_cycle(1'b1);

    // All wake sources low, writes must be dropped
    drive_cycle(1'b0, '0, '0, '0, '0, 4'b0000);
    wait_sleep(1'b1, "go to sleep");
    repeat (40) random_cycle(1'b0);

    // Writes to x0 while awake
    drive_cycle(1'b0, '0, '0, '0, '0, 4'b0001);
    wait_sleep(1'b0, "wake up");
    repeat (4) begin
      draw_bits(`RV_XLEN, v);
      drive_cycle(1'b1, '0, v, '0, '0, 4'b0001);
    end

    // Sweep every register on both ports
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      drive_cycle(1'b0, '0, '0, rv_shell_pkg::reg_addr_t'(i),
                  rv_shell_pkg::reg_addr_t'(`RV_NUM_REGS - 1 - i), 4'b0001);
    end
    repeat (2) @(posedge clk);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+verilog
verilog/rv_shell_pkg.sv
verilog/rv_rf_read_if.sv
verilog/rv_wake_ctrl.sv
verilog/rv_regfile_ecc.sv
verilog/rv_rf_check.sv
verilog/rv_core_shell.sv
bench/tb_clock_gen.sv
bench/tb_rv_core_shell.sv

/* run.sh */
#!/bin/sh
# Build and run the register file shell testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns \
  -f compile.f --top-module tb_rv_core_shell -o sim_rv_core_shell &&
out="$(./obj_dir/sim_rv_core_shell)"
status=$?
echo "$out"
[ "$status" -eq 0 ] &&
echo "$out" | grep -q "TEST RESULT: PASS" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* verilog/rv_core_shell.sv */
//////////////////////////////////////////////////////////////////////
// RISC-V core shell
// Wake control, ECC register file and read checker of a small core
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rv_shell_defs.svh"

module rv_core_shell (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Wake sources
  input  logic                    fetch_enable_i,
  input  logic                    core_busy_i,
  input  logic                    debug_req_i,
  input  logic                    irq_pending_i,
  input  logic                    irq_nm_i,

  // Register file ports
  input  logic                    rf_we_i,
  input  rv_shell_pkg::reg_addr_t rf_waddr_i,
  input  logic [`RV_XLEN-1:0]     rf_wdata_i,
  input  rv_shell_pkg::reg_addr_t rf_raddr_a_i,
  input  rv_shell_pkg::reg_addr_t rf_raddr_b_i,
  output logic [`RV_XLEN-1:0]     rf_rdata_a_o,
  output logic [`RV_XLEN-1:0]     rf_rdata_b_o,

  // Status
  output logic                    core_sleep_o,
  output logic                    alert_major_o
);

  logic clock_en;

  rv_rf_read_if rf_rd_if ();

  rv_wake_ctrl u_wake_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .core_busy_i    (core_busy_i),
    .debug_req_i    (debug_req_i),
    .irq_pending_i  (irq_pending_i),
    .irq_nm_i       (irq_nm_i),
    .clock_en_o     (clock_en),
    .core_sleep_o   (core_sleep_o)
  );

  // Clock enable qualifies writes in place of a gated clock
  rv_regfile_ecc u_regfile (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clock_en_i (clock_en),
    .we_i       (rf_we_i),
    .waddr_i    (rf_waddr_i),
    .wdata_i    (rf_wdata_i),
    .rd         (rf_rd_if.file)
  );

  rv_rf_check u_rf_check (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .raddr_a_i     (rf_raddr_a_i),
    .raddr_b_i     (rf_raddr_b_i),
    .rd            (rf_rd_if.check),
    .rdata_a_o     (rf_rdata_a_o),
    .rdata_b_o     (rf_rdata_b_o),
    .alert_major_o (alert_major_o)
  );

endmodule

`default_nettype wire

/* verilog/rv_regfile_ecc.sv */
//////////////////////////////////////////////////////////////////////
// ECC register file
// 32 encoded words, one write port qualified by the clock enable and
// two combinational read ports; x0 always reads as encoded zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rv_shell_defs.svh"

module rv_regfile_ecc (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clock_en_i,
  input  logic                    we_i,
  input  rv_shell_pkg::reg_addr_t waddr_i,
  input  logic [`RV_XLEN-1:0]     wdata_i,
  rv_rf_read_if.file              rd
);

  rv_shell_pkg::rf_word_t zero_word;
  rv_shell_pkg::rf_word_t wword;
  rv_shell_pkg::rf_word_t rf_q  [1:`RV_NUM_REGS-1];
  rv_shell_pkg::rf_word_t rf_rd [`RV_NUM_REGS];
  logic [`RV_NUM_REGS-1:1] we_dec;
  logic                    wr_go;

  assign zero_word.ecc  = rv_shell_pkg::ecc_encode('0);
  assign zero_word.data = '0;

  // Encode once at the write port
  assign wword.ecc  = rv_shell_pkg::ecc_encode(wdata_i);
  assign wword.data = wdata_i;

  // Writes only land while the shell is awake
  assign wr_go = clock_en_i & we_i;

  //////////////////////////////////////////////////////////////////////
  // Storage for x1 to x31
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 1; i < `RV_NUM_REGS; i++) begin : gen_entry
    assign we_dec[i] = wr_go && (waddr_i == rv_shell_pkg::reg_addr_t'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[i] <= zero_word;
      end else if (we_dec[i]) begin
        rf_q[i] <= wword;
      end
    end

    entry_hold_a : assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      !clock_en_i |=> $stable(rf_q[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////

  // x0 is hardwired, the rest come from the flops
  always_comb begin
    rf_rd[0] = zero_word;
    for (int i = 1; i < `RV_NUM_REGS; i++) begin
      rf_rd[i] = rf_q[i];
    end
  end

  assign rd.rword_a = rf_rd[rd.raddr_a];
  assign rd.rword_b = rf_rd[rd.raddr_b];

endmodule

`default_nettype wire

/* verilog/rv_rf_check.sv */
//////////////////////////////////////////////////////////////////////
// Register file read check
// Recomputes the check bits of both read words, returns the data and
// raises a registered major alert on any mismatch
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rv_shell_defs.svh"

module rv_rf_check (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  rv_shell_pkg::reg_addr_t raddr_a_i,
  input  rv_shell_pkg::reg_addr_t raddr_b_i,
  rv_rf_read_if.check             rd,
  output logic [`RV_XLEN-1:0]     rdata_a_o,
  output logic [`RV_XLEN-1:0]     rdata_b_o,
  output logic                    alert_major_o
);

  logic [`RV_ECC_BITS-1:0] syn_a;
  logic [`RV_ECC_BITS-1:0] syn_b;
  logic                    err_any;
  logic                    alert_q;

  // Addresses go straight to the file
  assign rd.raddr_a = raddr_a_i;
  assign rd.raddr_b = raddr_b_i;

  assign rdata_a_o = rd.rword_a.data;
  assign rdata_b_o = rd.rword_b.data;

  //////////////////////////////////////////////////////////////////////
  // Syndrome
  //////////////////////////////////////////////////////////////////////

  // Nonzero syndrome means the stored word was disturbed
  assign syn_a = rv_shell_pkg::ecc_encode(rd.rword_a.data) ^ rd.rword_a.ecc;
  assign syn_b = rv_shell_pkg::ecc_encode(rd.rword_b.data) ^ rd.rword_b.ecc;

  assign err_any = (|syn_a) | (|syn_b);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= err_any;
    end
  end

  assign alert_major_o = alert_q;

  // Catches undriven addresses or storage leaking X into the alert
  alert_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(alert_major_o)
  );

endmodule

`default_nettype wire

/* verilog/rv_rf_read_if.sv */
//////////////////////////////////////////////////////////////////////
// Register file read bundle
// Two read addresses and the two encoded words they select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface rv_rf_read_if;

  rv_shell_pkg::reg_addr_t raddr_a;
  rv_shell_pkg::reg_addr_t raddr_b;
  rv_shell_pkg::rf_word_t  rword_a;
  rv_shell_pkg::rf_word_t  rword_b;

  // Storage side
  modport file (
    input  raddr_a,
    input  raddr_b,
    output rword_a,
    output rword_b
  );

  // Checker side, which also owns the addresses
  modport check (
    output raddr_a,
    output raddr_b,
    input  rword_a,
    input  rword_b
  );

endinterface

`default_nettype wire

/* verilog/rv_shell_defs.svh */
//////////////////////////////////////////////////////////////////////
// RISC-V shell sizes
// Data width, check bits and register file geometry
//////////////////////////////////////////////////////////////////////

`ifndef RV_SHELL_DEFS_SVH
`define RV_SHELL_DEFS_SVH

// Word layout
`define RV_XLEN     32
`define RV_ECC_BITS 7

// Register file geometry
`define RV_NUM_REGS 32
`define RV_REG_AW   5

`endif

/* verilog/rv_shell_pkg.sv */
//////////////////////////////////////////////////////////////////////
// RISC-V shell package
// Register file word and address types plus the check-bit encoder
// shared by the register file and the read checker
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "rv_shell_defs.svh"

package rv_shell_pkg;

  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // Check bits sit above the data in the stored word
  typedef struct packed {
    logic [`RV_ECC_BITS-1:0] ecc;
    logic [`RV_XLEN-1:0]     data;
  } rf_word_t;

  //////////////////////////////////////////////////////////////////////
  // (39,32) Hsiao style encoder
  //////////////////////////////////////////////////////////////////////

  // One data mask per check bit, bit 0 at the right
  localparam logic [`RV_ECC_BITS-1:0][`RV_XLEN-1:0] ECC_MASK = {
    32'h98505586,
    32'h2DCC624C,
    32'hC2C1323B,
    32'h31234ED1,
    32'h413D89AA,
    32'hDEBA8050,
    32'h2606BD25
  };

  function automatic logic [`RV_ECC_BITS-1:0] ecc_encode(
    input logic [`RV_XLEN-1:0] data
  );
    logic [`RV_ECC_BITS-1:0] ecc;
    ecc = '0;
    for (int i = 0; i < `RV_ECC_BITS; i++) begin
      ecc[i] = ^(data & ECC_MASK[i]);
    end
    return ecc;
  endfunction

endpackage

`default_nettype wire

/* verilog/rv_wake_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Wake control
// Sticky fetch enable and busy register, combined with the debug and
// interrupt levels into the clock enable and the sleep flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rv_wake_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic fetch_enable_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic clock_en_o,
  output logic core_sleep_o
);

  logic fetch_enable_q;
  logic core_busy_q;
  logic wake_src;

  // Fetch enable is taken once and held until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Live debug and interrupt levels wake without delay
  assign wake_src     = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign clock_en_o   = fetch_enable_q & wake_src;
  assign core_sleep_o = ~clock_en_o;

  fetch_enable_sticky_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fetch_enable_q |=> fetch_enable_q
  );

endmodule

`default_nettype wire
